// ==== rtl/rom_check_pkg.sv ====
// rom integrity checker package with sizes, digest constants, FSM encodings and the digest mix
package rom_check_pkg;

  // rom geometry: the top RomTopCount words hold the expected digest
  localparam int RomDepth       = 16;
  localparam int RomTopCount    = 2;
  localparam int RomNonTopCount = RomDepth - RomTopCount;
  localparam int RomAw          = 4;
  localparam int RomDw          = 32;

  // addresses of the top word and of the last word that is absorbed
  localparam logic [RomAw-1:0] RomTopAddr        = RomAw'(RomDepth - 1);
  localparam logic [RomAw-1:0] RomLastNonTopAddr = RomAw'(RomNonTopCount - 1);

  // the image is loaded into the rom array at elaboration
  localparam string RomImageFile = "rom_image.hex";

  // default depth of the word FIFO between counter and checker
  localparam int FifoDepth = 4;

  // digest state and the constants of the stand-in mix
  localparam int                 DigestW    = 64;
  localparam logic [DigestW-1:0] DigestInit = 64'h6a09_e667_f3bc_c908;
  localparam logic [DigestW-1:0] DigestAddK = 64'h9e37_79b9_7f4a_7c15;

  // checker FSM encodings
  localparam logic [1:0] StAbsorb  = 2'd0;
  localparam logic [1:0] StWait    = 2'd1;
  localparam logic [1:0] StCapture = 2'd2;
  localparam logic [1:0] StDone    = 2'd3;

  // one absorb step: rotate left by 7, xor in the zero-extended word, add the constant
  function automatic logic [DigestW-1:0] digest_mix(
    input logic [DigestW-1:0] digest,
    input logic [RomDw-1:0]   word
  );
    logic [DigestW-1:0] rotated;
    rotated = {digest[DigestW-8:0], digest[DigestW-1:DigestW-7]};
    return (rotated ^ {{(DigestW - RomDw){1'b0}}, word}) + DigestAddK;
  endfunction

endpackage

// ==== rtl/rom_word_if.sv ====
// rom word interface carrying one word with its address and last-word flag under ready/valid
`timescale 1ns/10ps

interface rom_word_if;
  import rom_check_pkg::*;

  // a word moves in any cycle where valid and ready are both high
  logic             valid;
  logic             ready;
  logic [RomDw-1:0] data;
  logic [RomAw-1:0] addr;
  // marks the last word before the top words that hold the expected digest
  logic             last_nontop;

  // the address counter owns the control side of the read channel
  modport counter (
    output valid, addr, last_nontop,
    input  ready
  );

  // the rom output register supplies only the data word
  modport mem (
    output data
  );

  // the two sides of the word FIFO
  modport fifo_in (
    input  valid, data, addr, last_nontop,
    output ready
  );

  modport fifo_out (
    output valid, data, addr, last_nontop,
    input  ready
  );

  // the digest checker sinks words and applies back-pressure
  modport chk (
    input  valid, data, addr, last_nontop,
    output ready
  );

endinterface

// ==== rtl/rom_check_counter.sv ====
// rom address counter that walks every rom word in order and hands it on under ready/valid
`timescale 1ns/10ps

module rom_check_counter (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  output logic                            done_o,
  output logic [rom_check_pkg::RomAw-1:0] read_addr_o,
  rom_word_if.counter                     rd
);
  import rom_check_pkg::*;

  logic             req_q;
  logic             vld_q;
  logic             done_q;
  logic             done_d;
  logic             last_nontop_q;
  logic [RomAw-1:0] addr_q;
  logic [RomAw-1:0] addr_next;
  logic             xfer;
  logic             at_top;
  logic             go;

  // a word leaves when the FIFO takes it
  assign xfer = vld_q & rd.ready;
  assign at_top = addr_q == RomTopAddr;

  // the address only moves on a transfer below the top of the rom
  assign go = xfer & ~at_top;
  assign addr_next = addr_q + RomAw'(1);

  // the scan is over once the top word has been handed on
  assign done_d = done_q | (xfer & at_top);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else begin
      done_q <= done_d;
    end
  end

  // address and last flag advance together so the flag always matches addr_q
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q        <= '0;
      last_nontop_q <= 1'b0;
    end else if (go) begin
      addr_q        <= addr_next;
      last_nontop_q <= addr_next == RomLastNonTopAddr;
    end
  end

  // the request goes out in the first cycle after reset
  // valid follows it by a cycle, matching the rom output register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
      vld_q <= 1'b0;
    end else begin
      req_q <= ~done_d;
      vld_q <= req_q & ~done_d;
    end
  end

  // presenting the next address on a transfer lets the rom have the
  // following word ready one cycle later, so there is no bubble
  assign read_addr_o = go ? addr_next : addr_q;

  assign rd.valid       = vld_q;
  assign rd.addr        = addr_q;
  assign rd.last_nontop = last_nontop_q;
  assign done_o         = done_q;

endmodule

// ==== rtl/rom_check_mem.sv ====
// rom array loaded from the image file, read through a registered output
`timescale 1ns/10ps

module rom_check_mem (
  input  logic                            clk_i,
  rom_word_if.mem                         rd,
  input  logic [rom_check_pkg::RomAw-1:0] addr_i
);
  import rom_check_pkg::*;

  logic [RomDw-1:0] rom [RomDepth];
  logic [RomDw-1:0] data_q;

  // contents come from the hex image at elaboration
  initial begin
    $readmemh(RomImageFile, rom);
  end

  // the counter holds addr_i steady unless it advances, so the register
  // takes a new word exactly when the address moves and keeps it otherwise
  // data is therefore one cycle behind the address
  always_ff @(posedge clk_i) begin
    data_q <= rom[addr_i];
  end

  assign rd.data = data_q;

endmodule

// ==== rtl/rom_word_fifo.sv ====
// circular word FIFO between the rom reader and the digest checker
`timescale 1ns/10ps

module rom_word_fifo #(
  parameter int Depth = rom_check_pkg::FifoDepth
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  rom_word_if.fifo_in  in,
  rom_word_if.fifo_out out
);
  import rom_check_pkg::*;

  // entry storage, one array per field
  logic [RomDw-1:0]           data_mem [Depth];
  logic [RomAw-1:0]           addr_mem [Depth];
  logic                       last_mem [Depth];
  logic [$clog2(Depth)-1:0]   wr_ptr_q;
  logic [$clog2(Depth)-1:0]   rd_ptr_q;
  logic [$clog2(Depth+1)-1:0] count_q;
  logic                       push;
  logic                       pop;

  // pointers wrap at Depth, which need not be a power of two
  function automatic logic [$clog2(Depth)-1:0] ptr_inc(input logic [$clog2(Depth)-1:0] ptr);
    return (ptr == Depth - 1) ? '0 : ptr + 1'b1;
  endfunction

  // ready depends only on the fill level, never on the read side
  assign in.ready  = count_q != Depth;
  assign out.valid = count_q != '0;

  assign push = in.valid & in.ready;
  assign pop  = out.valid & out.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // a push and a pop in the same cycle leave the count unchanged
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_mem[wr_ptr_q] <= in.data;
      addr_mem[wr_ptr_q] <= in.addr;
      last_mem[wr_ptr_q] <= in.last_nontop;
    end
  end

  // the head entry is visible the cycle after it was written
  assign out.data        = data_mem[rd_ptr_q];
  assign out.addr        = addr_mem[rd_ptr_q];
  assign out.last_nontop = last_mem[rd_ptr_q];

endmodule

// ==== rtl/rom_digest_checker.sv ====
// digest checker that folds rom words into a digest and compares it with the top words
`timescale 1ns/10ps

module rom_digest_checker (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  rom_word_if.chk                           dg,
  output logic                              done_o,
  output logic                              good_o,
  output logic [rom_check_pkg::DigestW-1:0] digest_o
);
  import rom_check_pkg::*;

  logic [1:0]         state_q;
  logic [1:0]         state_d;
  logic [DigestW-1:0] digest_q;
  logic [DigestW-1:0] digest_d;
  logic [DigestW-1:0] expected_q;
  logic               last_q;
  logic               take;

  // words are accepted only while absorbing or capturing
  // the wait state and the done state hold ready low
  assign dg.ready = (state_q == StAbsorb) || (state_q == StCapture);
  assign take     = dg.valid & dg.ready;

  always_comb begin
    state_d  = state_q;
    digest_d = digest_q;
    case (state_q)
      StAbsorb: begin
        if (take) begin
          digest_d = digest_mix(digest_q, dg.data);
          // an odd word costs one extra cycle before the next one is taken
          if (dg.data[0]) begin
            state_d = StWait;
          end else if (dg.last_nontop) begin
            state_d = StCapture;
          end
        end
      end
      StWait: begin
        state_d = last_q ? StCapture : StAbsorb;
      end
      StCapture: begin
        // the top word closes the expected digest
        if (take && dg.addr == RomTopAddr) begin
          state_d = StDone;
        end
      end
      default: begin
        state_d = StDone;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= StAbsorb;
      digest_q <= DigestInit;
      last_q   <= 1'b0;
    end else begin
      state_q  <= state_d;
      digest_q <= digest_d;
      // remembers whether the word behind a wait cycle was the last to absorb
      if (take && state_q == StAbsorb) begin
        last_q <= dg.last_nontop;
      end
    end
  end

  // the top word is the upper half of the expected digest, the one below it the lower half
  always_ff @(posedge clk_i) begin
    if (take && state_q == StCapture) begin
      if (dg.addr == RomTopAddr) begin
        expected_q[DigestW-1 -: RomDw] <= dg.data;
      end else begin
        expected_q[RomDw-1:0] <= dg.data;
      end
    end
  end

  assign done_o   = state_q == StDone;
  // both halves are in place once the FSM reaches done
  assign good_o   = (state_q == StDone) && (digest_q == expected_q);
  assign digest_o = digest_q;

endmodule

// ==== rtl/rom_check_top.sv ====
// rom integrity checker top level joining counter, rom, FIFO and digest checker
`timescale 1ns/10ps

module rom_check_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  output logic                              done_o,
  output logic                              scan_done_o,
  output logic                              good_o,
  output logic [rom_check_pkg::DigestW-1:0] digest_o
);
  import rom_check_pkg::*;

  // read address from the counter to the rom array
  logic [RomAw-1:0] rom_addr;

  // rd_if runs from counter and rom into the FIFO, dg_if from the FIFO to the checker
  rom_word_if rd_if ();
  rom_word_if dg_if ();

  rom_check_counter u_counter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .done_o      (scan_done_o),
    .read_addr_o (rom_addr),
    .rd          (rd_if.counter)
  );

  rom_check_mem u_mem (
    .clk_i  (clk_i),
    .rd     (rd_if.mem),
    .addr_i (rom_addr)
  );

  rom_word_fifo #(
    .Depth (FifoDepth)
  ) u_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .in     (rd_if.fifo_in),
    .out    (dg_if.fifo_out)
  );

  rom_digest_checker u_checker (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .dg       (dg_if.chk),
    .done_o   (done_o),
    .good_o   (good_o),
    .digest_o (digest_o)
  );

endmodule

// ==== dv/rom_check_assert.sv ====
// handshake and FIFO level assertions bound into the word FIFO and the digest checker
`timescale 1ns/10ps

module rom_check_assert #(
  parameter int Depth     = rom_check_pkg::FifoDepth,
  parameter bit FifoLevel = 1'b1
) (
  input logic                            clk_i,
  input logic                            rst_ni,
  input logic                            valid_i,
  input logic                            ready_i,
  input logic [rom_check_pkg::RomDw-1:0] data_i,
  input logic [rom_check_pkg::RomAw-1:0] addr_i,
  input logic                            push_i,
  input logic                            pop_i,
  input logic [7:0]                      level_i
);

  // number of assertion failures so far
  int unsigned fail_count = 0;

  // a stalled word is offered again unchanged in the next cycle
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && !ready_i |=> valid_i && $stable(data_i) && $stable(addr_i))
    else begin
      $error("word changed or was withdrawn while stalled");
      fail_count++;
    end

  if (FifoLevel) begin : g_level
    // occupancy rebuilt from the push and pop strobes alone
    logic [7:0] shadow_level;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        shadow_level <= '0;
      end else begin
        shadow_level <= shadow_level + 8'(push_i) - 8'(pop_i);
      end
    end

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
      push_i |-> shadow_level < 8'(Depth))
      else begin
        $error("FIFO took a word while full");
        fail_count++;
      end

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pop_i |-> shadow_level != 8'd0)
      else begin
        $error("FIFO gave a word while empty");
        fail_count++;
      end

    // the fill count of the FIFO follows the words it actually moved
    a_level: assert property (@(posedge clk_i) disable iff (!rst_ni)
      level_i == shadow_level)
      else begin
        $error("FIFO fill count does not match the words pushed and popped");
        fail_count++;
      end
  end

endmodule

// the FIFO instance checks its input side and its own fill level
bind rom_word_fifo rom_check_assert #(
  .Depth (Depth)
) u_fifo_assert (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .valid_i (in.valid),
  .ready_i (in.ready),
  .data_i  (in.data),
  .addr_i  (in.addr),
  .push_i  (push),
  .pop_i   (pop),
  .level_i (8'(count_q))
);

// the checker instance only sees the handshake from the FIFO output
bind rom_digest_checker rom_check_assert #(
  .FifoLevel (1'b0)
) u_checker_assert (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .valid_i (dg.valid),
  .ready_i (dg.ready),
  .data_i  (dg.data),
  .addr_i  (dg.addr),
  .push_i  (1'b0),
  .pop_i   (1'b0),
  .level_i (8'd0)
);

// ==== dv/rom_check_monitor.sv ====
// monitor that watches the rom checker outputs and compares them with the expected results
`timescale 1ns/10ps

module rom_check_monitor (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              done_i,
  input  logic                              scan_done_i,
  input  logic                              good_i,
  input  logic [rom_check_pkg::DigestW-1:0] digest_i,
  input  logic [rom_check_pkg::DigestW-1:0] exp_digest_i,
  input  logic                              exp_good_i,
  output int unsigned                       err_count_o,
  output int unsigned                       run_count_o
);
  import rom_check_pkg::*;

  logic rst_prev = 1'b1;
  logic done_prev = 1'b0;
  logic scan_prev = 1'b0;

  task automatic report_mismatch(input string name, input logic [DigestW-1:0] got,
                                 input logic [DigestW-1:0] exp);
    if (got !== exp) begin
      err_count_o++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  initial begin
    err_count_o = 0;
    run_count_o = 0;
  end

  // outputs change just after the rising edge, so the edge itself sees settled values
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      done_prev = 1'b0;
      scan_prev = 1'b0;
    end else begin
      // the first sample after release still shows the reset state
      if (!rst_prev) begin
        report_mismatch("done_o", 64'(done_i), 64'd0);
        report_mismatch("scan_done_o", 64'(scan_done_i), 64'd0);
        report_mismatch("good_o", 64'(good_i), 64'd0);
        report_mismatch("digest_o", digest_i, DigestInit);
      end
      if ((done_prev && !done_i) || (scan_prev && !scan_done_i)) begin
        err_count_o++;
        $display("a done flag fell while reset was not asserted");
      end
      // word order changes the digest, so a match also rules out lost or repeated words
      if (done_i && !done_prev) begin
        run_count_o++;
        report_mismatch("digest_o", digest_i, exp_digest_i);
        report_mismatch("good_o", 64'(good_i), 64'(exp_good_i));
        if (!scan_done_i) begin
          err_count_o++;
          $display("scan_done_o was still low when done_o rose");
        end
      end
      done_prev = done_i;
      scan_prev = scan_done_i;
    end
    rst_prev = rst_ni;
  end

endmodule

// ==== dv/tb_rom_check.sv ====
// testbench for the rom integrity checker with clock, resets, reference digest and final report
`timescale 1ns/10ps

module tb_rom_check;
  import rom_check_pkg::*;

  localparam int ResetCycles   = 10;
  localparam int MidRunCycles  = 9;
  // two full runs plus the reset pulses
  localparam int TimeoutCycles = 2 * (RomDepth * 3 + 20) + 3 * ResetCycles;

  logic               clk;
  logic               rst_n;
  logic               done;
  logic               scan_done;
  logic               good;
  logic [DigestW-1:0] digest;
  logic [DigestW-1:0] exp_digest;
  logic               exp_good;
  logic [RomDw-1:0]   image [RomDepth];
  int unsigned        mon_errors;
  int unsigned        mon_runs;
  int unsigned        tb_errors;
  int unsigned        assert_errors;
  int unsigned        cycle_count = 0;

  rom_check_top DUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .done_o      (done),
    .scan_done_o (scan_done),
    .good_o      (good),
    .digest_o    (digest)
  );

  rom_check_monitor u_mon (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .done_i       (done),
    .scan_done_i  (scan_done),
    .good_i       (good),
    .digest_i     (digest),
    .exp_digest_i (exp_digest),
    .exp_good_i   (exp_good),
    .err_count_o  (mon_errors),
    .run_count_o  (mon_runs)
  );

  // one absorb step, the left rotation by 7 built from two shifts
  function automatic logic [DigestW-1:0] absorb_word(input logic [DigestW-1:0] d,
                                                     input logic [RomDw-1:0]   w);
    logic [DigestW-1:0] r;
    logic [DigestW-1:0] x;
    r = (d << 7) | (d >> (DigestW - 7));
    x = r ^ DigestW'(w);
    return x + DigestAddK;
  endfunction

  // folds every word below the two top words in address order
  function automatic logic [DigestW-1:0] ref_digest();
    logic [DigestW-1:0] d;
    d = DigestInit;
    for (int i = 0; i < RomNonTopCount; i++) begin
      d = absorb_word(d, image[i]);
    end
    return d;
  endfunction

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (ResetCycles) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic wait_done();
    while (!done) @(negedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TimeoutCycles) begin
      $display("run did not finish within %0d cycles", TimeoutCycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    rst_n     = 1'b0;
    tb_errors = 0;
    $readmemh("rom_image.hex", image);
    exp_digest = ref_digest();
    // the top word is the upper half of the expected digest
    exp_good   = exp_digest == {image[RomDepth-1], image[RomDepth-2]};
    apply_reset();
    wait_done();
    // cut the next walk short and make sure a fresh one ends the same way
    apply_reset();
    repeat (MidRunCycles) @(negedge clk);
    if (done) begin
      tb_errors++;
      $display("done_o rose before the mid-run reset was applied");
    end
    apply_reset();
    wait_done();
    repeat (4) @(negedge clk);
    if (mon_runs != 2) begin
      tb_errors++;
      $display("expected two finished runs, the monitor saw %0d", mon_runs);
    end
    assert_errors = DUT.u_fifo.u_fifo_assert.fail_count
                  + DUT.u_checker.u_checker_assert.fail_count;
    $display("errors: monitor %0d, testbench %0d, assertions %0d",
             mon_errors, tb_errors, assert_errors);
    if (mon_errors + tb_errors + assert_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
rtl/rom_check_pkg.sv
rtl/rom_word_if.sv
rtl/rom_check_counter.sv
rtl/rom_check_mem.sv
rtl/rom_word_fifo.sv
rtl/rom_digest_checker.sv
rtl/rom_check_top.sv
dv/rom_check_assert.sv
dv/rom_check_monitor.sv
dv/tb_rom_check.sv

// ==== Makefile ====
# Verilator build and run for the rom integrity checker
VERILATOR ?= verilator
TOP       ?= tb_rom_check
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TEST PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass message appears as a line of its own
run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== rom_image.hex ====
// one 32-bit word per line from address 0 up
// words 14 and 15 hold the lower and upper half of the expected digest
13579bdf
2468ace0
0badf00d
deadbeef
c0ffee01
8badf00d
00000000
ffffffff
12345678
87654321
a5a5a5a5
5a5a5a5a
0f1e2d3c
4b5a6979
3c2d1e0f
78695a4b
